// File: filelist.f
design/periph_bus_pkg.sv
design/periph_irq_pkg.sv
design/periph_addr_decode.sv
design/gpio_block.sv
design/timer_block.sv
design/irq_ctrl.sv
design/periph_rsp_mux.sv
design/peripheral_subsystem.sv
dv/peripheral_subsystem_assert.sv
dv/peripheral_subsystem_tb.sv

// File: Bender.yml
package:
  name: peripheral_subsystem

sources:
  - files:
      - design/periph_bus_pkg.sv
      - design/periph_irq_pkg.sv
      - design/periph_addr_decode.sv
      - design/gpio_block.sv
      - design/timer_block.sv
      - design/irq_ctrl.sv
      - design/periph_rsp_mux.sv
      - design/peripheral_subsystem.sv
  - target: test
    files:
      - dv/peripheral_subsystem_assert.sv
      - dv/peripheral_subsystem_tb.sv

// File: dv/peripheral_subsystem_tb.sv
// ------------------------------------------------
// Table-driven testbench for the peripheral
// subsystem with bus, pin and interrupt checks
// ------------------------------------------------
`timescale 1ns/1ps

module peripheral_subsystem_tb;

  localparam int unsigned GPIO_W      = 16;
  localparam int unsigned RSP_TIMEOUT = 20;
  localparam int unsigned IRQ_TIMEOUT = 1000;
  // Sync, edge detect and pending take 4 cycles
  localparam int unsigned PIN_SETTLE  = 6;

  typedef periph_bus_pkg::bus_addr_t addr_t;
  typedef periph_bus_pkg::bus_data_t data_t;

  localparam logic [3:0] OP_WR       = 4'd0;
  localparam logic [3:0] OP_RD       = 4'd1;
  localparam logic [3:0] OP_RD_MIN   = 4'd2;
  localparam logic [3:0] OP_CLAIM    = 4'd3;
  localparam logic [3:0] OP_BURST    = 4'd4;
  localparam logic [3:0] OP_PINS     = 4'd5;
  localparam logic [3:0] OP_EXT      = 4'd6;
  localparam logic [3:0] OP_OUTS     = 4'd7;
  localparam logic [3:0] OP_LEVELS   = 4'd8;
  localparam logic [3:0] OP_WAIT_IRQ = 4'd9;

  localparam addr_t IRQ_BASE   = addr_t'(periph_bus_pkg::BLK_IRQ) << 8;
  localparam addr_t GPIO_BASE  = addr_t'(periph_bus_pkg::BLK_GPIO) << 8;
  localparam addr_t TIMER_BASE = addr_t'(periph_bus_pkg::BLK_TIMER) << 8;

  localparam addr_t A_PENDING    = IRQ_BASE | (periph_bus_pkg::IRQ_PENDING << 2);
  localparam addr_t A_ENABLE     = IRQ_BASE | (periph_bus_pkg::IRQ_ENABLE << 2);
  localparam addr_t A_CLAIM      = IRQ_BASE | (periph_bus_pkg::IRQ_CLAIM << 2);
  localparam addr_t A_MSIP       = IRQ_BASE | (periph_bus_pkg::IRQ_MSIP << 2);
  localparam addr_t A_DATA_IN    = GPIO_BASE | (periph_bus_pkg::GPIO_DATA_IN << 2);
  localparam addr_t A_DATA_OUT   = GPIO_BASE | (periph_bus_pkg::GPIO_DATA_OUT << 2);
  localparam addr_t A_OUT_EN     = GPIO_BASE | (periph_bus_pkg::GPIO_OUT_EN << 2);
  localparam addr_t A_INTR_EN    = GPIO_BASE | (periph_bus_pkg::GPIO_INTR_EN << 2);
  localparam addr_t A_INTR_STATE = GPIO_BASE | (periph_bus_pkg::GPIO_INTR_STATE << 2);
  localparam addr_t A_MTIME      = TIMER_BASE | (periph_bus_pkg::TIMER_MTIME << 2);
  localparam addr_t A_MTIMECMP   = TIMER_BASE | (periph_bus_pkg::TIMER_MTIMECMP << 2);
  localparam addr_t A_CTRL       = TIMER_BASE | (periph_bus_pkg::TIMER_CTRL << 2);

  typedef struct packed {
    logic [3:0]        op;
    addr_t             addr;
    data_t             wdata;
    logic [GPIO_W-1:0] pins;
    data_t             exp;
    logic              exp_err;
  } step_t;

  logic              clk_i, reset_i, req_i, we_i;
  addr_t             addr_i;
  data_t             wdata_i, rdata_o;
  logic              rvalid_o, err_o, irq_o, msip_o;
  logic [7:0]        irq_ext_i;
  logic [GPIO_W-1:0] gpio_i, gpio_o, gpio_en_o;

  step_t             steps[$];
  logic [GPIO_W-1:0] rnd_out, rnd_en, rnd_in;
  int unsigned       k;

  peripheral_subsystem #(
    .GPIO_W     (GPIO_W),
    .PRESCALE_W (8)
  ) uut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .we_i      (we_i),
    .addr_i    (addr_i),
    .wdata_i   (wdata_i),
    .rvalid_o  (rvalid_o),
    .rdata_o   (rdata_o),
    .err_o     (err_o),
    .irq_ext_i (irq_ext_i),
    .irq_o     (irq_o),
    .msip_o    (msip_o),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o)
  );

  bind peripheral_subsystem peripheral_subsystem_assert u_assert (
    .clk_i, .reset_i, .req_i, .rvalid_o,
    .rdata_o, .err_o, .irq_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1);
  endtask

  always @(negedge clk_i) begin
    if (uut.u_assert.fail_count != 0) begin
      $display("A bound assertion on the bus or interrupt ports failed");
      abort_run();
    end
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_at_least(input string name, input data_t got, input data_t lim);
    if (got < lim) begin
      $display("CHECK FAILED at %0t: %s got %h expected at least %h", $time, name, got, lim);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_irq_id(input string name, input periph_irq_pkg::irq_id_t got,
                              input periph_irq_pkg::irq_id_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pins(input string name, input logic [GPIO_W-1:0] got,
                            input logic [GPIO_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // One request strobe, then wait for its response
  task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                            output data_t rdata, output logic err);
    int unsigned n;
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
    n     = 0;
    while (!rvalid_o) begin
      if (n == RSP_TIMEOUT) begin
        $display("Timeout: no rvalid_o for the access to %h", addr);
        abort_run();
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  // Two reads on consecutive cycles
  task automatic read_burst(input addr_t addr, input data_t exp);
    @(negedge clk_i);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    @(negedge clk_i);
    check_level("rvalid_o", rvalid_o, 1'b1);
    check_data("rdata_o", rdata_o, exp);
    @(negedge clk_i);
    req_i = 1'b0;
    check_level("rvalid_o", rvalid_o, 1'b1);
    check_data("rdata_o", rdata_o, exp);
  endtask

  task automatic wait_irq();
    int unsigned n;
    n = 0;
    while (!irq_o) begin
      if (n == IRQ_TIMEOUT) begin
        $display("Timeout: irq_o never went high");
        abort_run();
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
  endtask

  task automatic add_step(input logic [3:0] op, input addr_t addr, input data_t wdata,
                          input logic [GPIO_W-1:0] pins, input data_t exp,
                          input logic exp_err);
    step_t s;
    s.op      = op;
    s.addr    = addr;
    s.wdata   = wdata;
    s.pins    = pins;
    s.exp     = exp;
    s.exp_err = exp_err;
    steps.push_back(s);
  endtask

  task automatic build_table();
    data_t gpio_id;
    gpio_id = periph_irq_pkg::SRC_GPIO_BASE + k;
    // Reset values
    add_step(OP_OUTS, '0, '0, '0, '0, 1'b0);
    add_step(OP_LEVELS, '0, '0, '0, '0, 1'b0);
    add_step(OP_RD, A_ENABLE, '0, '0, '0, 1'b0);
    add_step(OP_RD, A_DATA_OUT, '0, '0, '0, 1'b0);
    add_step(OP_RD, A_OUT_EN, '0, '0, '0, 1'b0);
    add_step(OP_RD, A_MTIMECMP, '0, '0, '1, 1'b0);
    // GPIO outputs and inputs
    add_step(OP_WR, A_DATA_OUT, data_t'(rnd_out), '0, '0, 1'b0);
    add_step(OP_WR, A_OUT_EN, data_t'(rnd_en), '0, '0, 1'b0);
    add_step(OP_OUTS, '0, '0, rnd_en, data_t'(rnd_out), 1'b0);
    add_step(OP_RD, A_DATA_OUT, '0, '0, data_t'(rnd_out), 1'b0);
    add_step(OP_RD, A_OUT_EN, '0, '0, data_t'(rnd_en), 1'b0);
    add_step(OP_PINS, '0, '0, rnd_in, '0, 1'b0);
    add_step(OP_RD, A_DATA_IN, '0, '0, data_t'(rnd_in), 1'b0);
    add_step(OP_BURST, A_DATA_OUT, '0, '0, data_t'(rnd_out), 1'b0);
    // Block 3 and high address bits are unmapped
    add_step(OP_WR, 32'h0000_0304, data_t'(~rnd_out), '0, '0, 1'b1);
    add_step(OP_WR, A_DATA_OUT | 32'h0001_0000, data_t'(~rnd_out), '0, '0, 1'b1);
    add_step(OP_RD, A_DATA_OUT | 32'h8000_0000, '0, '0, '0, 1'b1);
    add_step(OP_RD, 32'h0000_0300, '0, '0, '0, 1'b1);
    add_step(OP_RD, A_DATA_OUT, '0, '0, data_t'(rnd_out), 1'b0);
    add_step(OP_OUTS, '0, '0, rnd_en, data_t'(rnd_out), 1'b0);
    // Rising edge on pin k
    add_step(OP_PINS, '0, '0, '0, '0, 1'b0);
    add_step(OP_WR, A_INTR_STATE, '1, '0, '0, 1'b0);
    add_step(OP_WR, A_INTR_EN, data_t'(1) << k, '0, '0, 1'b0);
    add_step(OP_WR, A_ENABLE, data_t'(1) << gpio_id, '0, '0, 1'b0);
    add_step(OP_LEVELS, '0, '0, '0, '0, 1'b0);
    add_step(OP_PINS, '0, '0, GPIO_W'(1) << k, '0, 1'b0);
    add_step(OP_WAIT_IRQ, '0, '0, '0, '0, 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, gpio_id, 1'b0);
    add_step(OP_WR, A_INTR_STATE, '1, '0, '0, 1'b0);
    // Line was still high after the first claim, so it pended again
    add_step(OP_CLAIM, '0, '0, '0, gpio_id, 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, '0, 1'b0);
    add_step(OP_LEVELS, '0, '0, '0, '0, 1'b0);
    // External line 3 and a GPIO edge together
    add_step(OP_PINS, '0, '0, '0, '0, 1'b0);
    add_step(OP_WR, A_ENABLE, (data_t'(1) << 4) | (data_t'(1) << gpio_id), '0, '0, 1'b0);
    add_step(OP_EXT, '0, 32'h08, '0, '0, 1'b0);
    add_step(OP_PINS, '0, '0, GPIO_W'(1) << k, '0, 1'b0);
    add_step(OP_EXT, '0, '0, '0, '0, 1'b0);
    add_step(OP_WR, A_INTR_STATE, '1, '0, '0, 1'b0);
    add_step(OP_RD, A_PENDING, '0, '0, (data_t'(1) << 4) | (data_t'(1) << gpio_id), 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, 32'd4, 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, gpio_id, 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, '0, 1'b0);
    add_step(OP_WR, A_MSIP, 32'd1, '0, '0, 1'b0);
    add_step(OP_LEVELS, '0, '0, '0, 32'd2, 1'b0);
    add_step(OP_WR, A_MSIP, '0, '0, '0, 1'b0);
    add_step(OP_LEVELS, '0, '0, '0, '0, 1'b0);
    // Timer expiry at MTIME 20 with prescale 3
    add_step(OP_WR, A_ENABLE, data_t'(1) << periph_irq_pkg::SRC_TIMER, '0, '0, 1'b0);
    add_step(OP_WR, A_MTIMECMP, 32'd20, '0, '0, 1'b0);
    add_step(OP_WR, A_CTRL, (32'd3 << 8) | 32'd1, '0, '0, 1'b0);
    add_step(OP_WAIT_IRQ, '0, '0, '0, '0, 1'b0);
    add_step(OP_CLAIM, '0, '0, '0, periph_irq_pkg::SRC_TIMER, 1'b0);
    add_step(OP_RD_MIN, A_MTIME, '0, '0, 32'd20, 1'b0);
  endtask

  task automatic apply_step(input step_t s);
    data_t rdata;
    logic  err;
    case (s.op)
      OP_WR: begin
        bus_access(1'b1, s.addr, s.wdata, rdata, err);
        check_err("err_o", err, s.exp_err);
        check_data("rdata_o", rdata, '0);
      end
      OP_RD: begin
        bus_access(1'b0, s.addr, '0, rdata, err);
        check_err("err_o", err, s.exp_err);
        check_data("rdata_o", rdata, s.exp);
      end
      OP_RD_MIN: begin
        bus_access(1'b0, s.addr, '0, rdata, err);
        check_err("err_o", err, s.exp_err);
        check_at_least("rdata_o", rdata, s.exp);
      end
      OP_CLAIM: begin
        bus_access(1'b0, A_CLAIM, '0, rdata, err);
        check_err("err_o", err, 1'b0);
        check_irq_id("claim id", periph_irq_pkg::irq_id_t'(rdata),
                     periph_irq_pkg::irq_id_t'(s.exp));
      end
      OP_BURST: read_burst(s.addr, s.exp);
      OP_PINS: begin
        @(negedge clk_i);
        gpio_i = s.pins;
        repeat (PIN_SETTLE) @(negedge clk_i);
      end
      OP_EXT: begin
        @(negedge clk_i);
        irq_ext_i = s.wdata[7:0];
        repeat (2) @(negedge clk_i);
      end
      OP_OUTS: begin
        check_pins("gpio_o", gpio_o, s.exp[GPIO_W-1:0]);
        check_pins("gpio_en_o", gpio_en_o, s.pins);
      end
      OP_LEVELS: begin
        check_level("irq_o", irq_o, s.exp[0]);
        check_level("msip_o", msip_o, s.exp[1]);
      end
      OP_WAIT_IRQ: wait_irq();
      default: begin
        $display("Unknown operation %0d in the stimulus table", s.op);
        abort_run();
      end
    endcase
  endtask

  initial begin
    int unsigned seed_word;
    seed_word = $urandom(32'h353a);
    reset_i   = 1'b1;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    irq_ext_i = '0;
    gpio_i    = '0;
    rnd_out   = GPIO_W'($urandom);
    rnd_en    = GPIO_W'($urandom);
    rnd_in    = GPIO_W'($urandom);
    k         = $urandom % GPIO_W;
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    build_table();
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    if (uut.u_assert.fail_count != 0) begin
      $display("A bound assertion on the bus or interrupt ports failed");
      abort_run();
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule

// File: dv/peripheral_subsystem_assert.sv
// ------------------------------------------------
// Bus response and interrupt port assertions
// ------------------------------------------------
`timescale 1ns/1ps

module peripheral_subsystem_assert (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      req_i,
  input logic                      rvalid_o,
  input periph_bus_pkg::bus_data_t rdata_o,
  input logic                      err_o,
  input logic                      irq_o
);

  int unsigned fail_count = 0;

  // One response per request, one cycle later
  rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (reset_i) !$past(reset_i) |-> (rvalid_o == $past(req_i))
  ) else begin
    fail_count++;
    $error("rvalid_o does not match req_i of the previous cycle");
  end

  err_zero_data: assert property (
    @(posedge clk_i) err_o |-> (rdata_o == '0)
  ) else begin
    fail_count++;
    $error("err_o set with nonzero rdata_o");
  end

  // Outputs leave reset quiet
  quiet_after_reset: assert property (
    @(posedge clk_i) $fell(reset_i) |-> (!irq_o && !rvalid_o)
  ) else begin
    fail_count++;
    $error("irq_o or rvalid_o high during reset");
  end

endmodule

// File: design/peripheral_subsystem.sv
// ------------------------------------------------
// Peripheral subsystem: bus decode, IRQ, GPIO and
// timer blocks with a registered response
// ------------------------------------------------
`timescale 1ns/1ps

module peripheral_subsystem #(
  parameter int unsigned GPIO_W     = 16,
  parameter int unsigned PRESCALE_W = 8
) (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  periph_bus_pkg::bus_addr_t           addr_i,
  input  periph_bus_pkg::bus_data_t           wdata_i,
  output logic                                rvalid_o,
  output periph_bus_pkg::bus_data_t           rdata_o,
  output logic                                err_o,
  input  logic [periph_irq_pkg::NUM_EXT-1:0]  irq_ext_i,
  output logic                                irq_o,
  output logic                                msip_o,
  input  logic [GPIO_W-1:0]                   gpio_i,
  output logic [GPIO_W-1:0]                   gpio_o,
  output logic [GPIO_W-1:0]                   gpio_en_o
);

  localparam int unsigned NUM_SRC = periph_irq_pkg::SRC_GPIO_BASE + GPIO_W;

  logic                      irq_req, gpio_req, timer_req;
  logic                      blk_we;
  periph_bus_pkg::bus_data_t blk_wdata;
  periph_bus_pkg::reg_off_t  blk_off;
  periph_bus_pkg::blk_idx_t  blk_sel;
  logic                      dec_err;
  periph_bus_pkg::bus_data_t irq_rdata, gpio_rdata, timer_rdata;
  logic                      timer_expired;
  logic [GPIO_W-1:0]         gpio_intr;
  logic [NUM_SRC-1:0]        irq_src;

  // Source vector, ID 0 reserved
  assign irq_src[0] = 1'b0;
  assign irq_src[periph_irq_pkg::SRC_EXT_BASE +: periph_irq_pkg::NUM_EXT] = irq_ext_i;
  assign irq_src[periph_irq_pkg::SRC_TIMER] = timer_expired;
  assign irq_src[periph_irq_pkg::SRC_GPIO_BASE +: GPIO_W] = gpio_intr;

  periph_addr_decode u_decode (
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .irq_req_o   (irq_req),
    .gpio_req_o  (gpio_req),
    .timer_req_o (timer_req),
    .we_o        (blk_we),
    .wdata_o     (blk_wdata),
    .off_o       (blk_off),
    .sel_o       (blk_sel),
    .dec_err_o   (dec_err)
  );

  irq_ctrl #(.NUM_SRC(NUM_SRC)) u_irq (
    .clk_i, .reset_i,
    .req_i   (irq_req),
    .we_i    (blk_we),
    .off_i   (blk_off),
    .wdata_i (blk_wdata),
    .rdata_o (irq_rdata),
    .src_i   (irq_src),
    .irq_o   (irq_o),
    .msip_o  (msip_o)
  );

  gpio_block #(.GPIO_W(GPIO_W)) u_gpio (
    .clk_i, .reset_i,
    .req_i     (gpio_req),
    .we_i      (blk_we),
    .off_i     (blk_off),
    .wdata_i   (blk_wdata),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_en_o (gpio_en_o),
    .intr_o    (gpio_intr)
  );

  timer_block #(.PRESCALE_W(PRESCALE_W)) u_timer (
    .clk_i, .reset_i,
    .req_i     (timer_req),
    .we_i      (blk_we),
    .off_i     (blk_off),
    .wdata_i   (blk_wdata),
    .rdata_o   (timer_rdata),
    .expired_o (timer_expired)
  );

  periph_rsp_mux u_rsp (
    .clk_i, .reset_i,
    .req_i         (req_i),
    .we_i          (we_i),
    .sel_i         (blk_sel),
    .dec_err_i     (dec_err),
    .irq_rdata_i   (irq_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o)
  );

endmodule

// File: design/periph_rsp_mux.sv
// ------------------------------------------------
// Response stage: one-cycle rvalid, rdata, err
// ------------------------------------------------
`timescale 1ns/1ps

module periph_rsp_mux (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  periph_bus_pkg::blk_idx_t  sel_i,
  input  logic                      dec_err_i,
  input  periph_bus_pkg::bus_data_t irq_rdata_i,
  input  periph_bus_pkg::bus_data_t gpio_rdata_i,
  input  periph_bus_pkg::bus_data_t timer_rdata_i,
  output logic                      rvalid_o,
  output periph_bus_pkg::bus_data_t rdata_o,
  output logic                      err_o
);

  periph_bus_pkg::bus_data_t sel_rdata;

  always_comb begin
    case (sel_i)
      periph_bus_pkg::BLK_IRQ:   sel_rdata = irq_rdata_i;
      periph_bus_pkg::BLK_GPIO:  sel_rdata = gpio_rdata_i;
      periph_bus_pkg::BLK_TIMER: sel_rdata = timer_rdata_i;
      default:                   sel_rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= req_i;
      err_o    <= req_i && dec_err_i;
      // Writes and errors return zero
      rdata_o  <= (req_i && !we_i && !dec_err_i) ? sel_rdata : '0;
    end
  end

endmodule

// File: design/irq_ctrl.sv
// ------------------------------------------------
// Interrupt controller: pending, enable, claim of
// the lowest pending ID, and software interrupt
// ------------------------------------------------
`timescale 1ns/1ps

module irq_ctrl #(
  parameter int unsigned NUM_SRC = 26
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  periph_bus_pkg::reg_off_t  off_i,
  input  periph_bus_pkg::bus_data_t wdata_i,
  output periph_bus_pkg::bus_data_t rdata_o,
  input  logic [NUM_SRC-1:0]        src_i,
  output logic                      irq_o,
  output logic                      msip_o
);

  logic [NUM_SRC-1:0]      pending_q, enable_q;
  logic [NUM_SRC-1:0]      claim_mask;
  periph_irq_pkg::irq_id_t claim_id;
  logic                    claim_rd;
  logic                    msip_q;
  logic                    wr;

  assign wr       = req_i && we_i;
  assign claim_rd = req_i && !we_i && (off_i == periph_bus_pkg::IRQ_CLAIM);

  // Lowest pending ID wins, 0 when idle
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (pending_q[i]) claim_id = periph_irq_pkg::irq_id_t'(i);
    end
  end

  always_comb begin
    claim_mask = '0;
    if (claim_rd) claim_mask[claim_id] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      // A claim beats a new set on the same edge
      pending_q <= (pending_q | (src_i & enable_q)) & ~claim_mask;
      if (wr && off_i == periph_bus_pkg::IRQ_ENABLE) enable_q <= wdata_i[NUM_SRC-1:0];
      if (wr && off_i == periph_bus_pkg::IRQ_MSIP) msip_q <= wdata_i[0];
    end
  end

  always_comb begin
    rdata_o = '0;
    case (off_i)
      periph_bus_pkg::IRQ_PENDING: rdata_o[NUM_SRC-1:0] = pending_q;
      periph_bus_pkg::IRQ_ENABLE:  rdata_o[NUM_SRC-1:0] = enable_q;
      periph_bus_pkg::IRQ_CLAIM:   rdata_o[$bits(periph_irq_pkg::irq_id_t)-1:0] = claim_id;
      periph_bus_pkg::IRQ_MSIP:    rdata_o[0] = msip_q;
      default:                     rdata_o = '0;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

endmodule

// File: design/timer_block.sv
// ------------------------------------------------
// Machine timer with prescaler and compare IRQ
// ------------------------------------------------
`timescale 1ns/1ps

module timer_block #(
  parameter int unsigned PRESCALE_W = 8
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  periph_bus_pkg::reg_off_t  off_i,
  input  periph_bus_pkg::bus_data_t wdata_i,
  output periph_bus_pkg::bus_data_t rdata_o,
  output logic                      expired_o
);

  periph_bus_pkg::bus_data_t mtime_q, mtimecmp_q;
  logic [PRESCALE_W-1:0]     prescale_q, cnt_q;
  logic                      en_q;
  logic                      tick;
  logic                      wr;

  assign wr   = req_i && we_i;
  // One MTIME step every prescale + 1 cycles
  assign tick = en_q && (cnt_q == prescale_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      prescale_q <= '0;
      cnt_q      <= '0;
      en_q       <= 1'b0;
    end else begin
      if (en_q) cnt_q <= tick ? '0 : cnt_q + 1'b1;
      if (wr && off_i == periph_bus_pkg::TIMER_MTIME) begin
        mtime_q <= wdata_i;
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr && off_i == periph_bus_pkg::TIMER_MTIMECMP) mtimecmp_q <= wdata_i;
      if (wr && off_i == periph_bus_pkg::TIMER_CTRL) begin
        en_q       <= wdata_i[periph_bus_pkg::TIMER_CTRL_EN_BIT];
        prescale_q <= wdata_i[periph_bus_pkg::TIMER_CTRL_PRE_LSB +: PRESCALE_W];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (off_i)
      periph_bus_pkg::TIMER_MTIME:    rdata_o = mtime_q;
      periph_bus_pkg::TIMER_MTIMECMP: rdata_o = mtimecmp_q;
      periph_bus_pkg::TIMER_CTRL: begin
        rdata_o[periph_bus_pkg::TIMER_CTRL_EN_BIT] = en_q;
        rdata_o[periph_bus_pkg::TIMER_CTRL_PRE_LSB +: PRESCALE_W] = prescale_q;
      end
      default: rdata_o = '0;
    endcase
  end

  assign expired_o = en_q && (mtime_q >= mtimecmp_q);

endmodule

// File: design/gpio_block.sv
// ------------------------------------------------
// GPIO: pin sync, output drive and rising-edge
// interrupts
// ------------------------------------------------
`timescale 1ns/1ps

module gpio_block #(
  parameter int unsigned GPIO_W = 16
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  periph_bus_pkg::reg_off_t  off_i,
  input  periph_bus_pkg::bus_data_t wdata_i,
  output periph_bus_pkg::bus_data_t rdata_o,
  input  logic [GPIO_W-1:0]         gpio_i,
  output logic [GPIO_W-1:0]         gpio_o,
  output logic [GPIO_W-1:0]         gpio_en_o,
  output logic [GPIO_W-1:0]         intr_o
);

  logic [GPIO_W-1:0] sync_q, data_in_q, data_prev_q;
  logic [GPIO_W-1:0] data_out_q, out_en_q, intr_en_q, intr_state_q;
  logic [GPIO_W-1:0] rise;
  logic              wr;

  assign wr   = req_i && we_i;
  assign rise = data_in_q & ~data_prev_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q       <= '0;
      data_in_q    <= '0;
      data_prev_q  <= '0;
      data_out_q   <= '0;
      out_en_q     <= '0;
      intr_en_q    <= '0;
      intr_state_q <= '0;
    end else begin
      sync_q      <= gpio_i;
      data_in_q   <= sync_q;
      data_prev_q <= data_in_q;
      if (wr && off_i == periph_bus_pkg::GPIO_DATA_OUT) data_out_q <= wdata_i[GPIO_W-1:0];
      if (wr && off_i == periph_bus_pkg::GPIO_OUT_EN) out_en_q <= wdata_i[GPIO_W-1:0];
      if (wr && off_i == periph_bus_pkg::GPIO_INTR_EN) intr_en_q <= wdata_i[GPIO_W-1:0];
      // Write one to clear, new edges win
      if (wr && off_i == periph_bus_pkg::GPIO_INTR_STATE) begin
        intr_state_q <= (intr_state_q & ~wdata_i[GPIO_W-1:0]) | rise;
      end else begin
        intr_state_q <= intr_state_q | rise;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (off_i)
      periph_bus_pkg::GPIO_DATA_IN:    rdata_o[GPIO_W-1:0] = data_in_q;
      periph_bus_pkg::GPIO_DATA_OUT:   rdata_o[GPIO_W-1:0] = data_out_q;
      periph_bus_pkg::GPIO_OUT_EN:     rdata_o[GPIO_W-1:0] = out_en_q;
      periph_bus_pkg::GPIO_INTR_EN:    rdata_o[GPIO_W-1:0] = intr_en_q;
      periph_bus_pkg::GPIO_INTR_STATE: rdata_o[GPIO_W-1:0] = intr_state_q;
      default:                         rdata_o = '0;
    endcase
  end

  assign gpio_o    = data_out_q;
  assign gpio_en_o = out_en_q;
  assign intr_o    = intr_state_q & intr_en_q;

endmodule

// File: design/periph_addr_decode.sv
// ------------------------------------------------
// Address decoder: block strobe, word offset and
// unmapped-access flag for each bus request
// ------------------------------------------------
`timescale 1ns/1ps

module periph_addr_decode (
  input  logic                     req_i,
  input  logic                     we_i,
  input  periph_bus_pkg::bus_addr_t addr_i,
  input  periph_bus_pkg::bus_data_t wdata_i,
  output logic                     irq_req_o,
  output logic                     gpio_req_o,
  output logic                     timer_req_o,
  output logic                     we_o,
  output periph_bus_pkg::bus_data_t wdata_o,
  output periph_bus_pkg::reg_off_t  off_o,
  output periph_bus_pkg::blk_idx_t  sel_o,
  output logic                     dec_err_o
);

  logic hi_bits;
  logic mapped;

  assign sel_o = addr_i[periph_bus_pkg::ADDR_BLK_LSB +: $bits(periph_bus_pkg::blk_idx_t)];
  assign off_o = addr_i[periph_bus_pkg::ADDR_OFF_LSB +: $bits(periph_bus_pkg::reg_off_t)];

  // Anything above the block field must be zero
  assign hi_bits = |addr_i[$bits(periph_bus_pkg::bus_addr_t)-1:periph_bus_pkg::ADDR_HI_LSB];
  assign mapped  = !hi_bits && (sel_o != 2'd3);

  assign dec_err_o = !mapped;

  assign irq_req_o   = req_i && mapped && (sel_o == periph_bus_pkg::BLK_IRQ);
  assign gpio_req_o  = req_i && mapped && (sel_o == periph_bus_pkg::BLK_GPIO);
  assign timer_req_o = req_i && mapped && (sel_o == periph_bus_pkg::BLK_TIMER);

  assign we_o    = we_i;
  assign wdata_o = wdata_i;

endmodule

// File: design/periph_irq_pkg.sv
// ------------------------------------------------
// Interrupt ID width and source layout
// ------------------------------------------------
package periph_irq_pkg;

  typedef logic [4:0] irq_id_t;

  // ID 0 is reserved and never pending
  localparam int unsigned NUM_EXT = 8;

  // External lines occupy IDs 1 to 8
  localparam int unsigned SRC_EXT_BASE = 1;

  localparam int unsigned SRC_TIMER = 9;

  // GPIO pins follow the timer
  localparam int unsigned SRC_GPIO_BASE = 10;

endpackage

// File: design/periph_bus_pkg.sv
// ------------------------------------------------
// Peripheral bus definitions: widths, block map
// and register word offsets
// ------------------------------------------------
package periph_bus_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [5:0]  reg_off_t;
  typedef logic [1:0]  blk_idx_t;

  // Address map fields
  localparam int unsigned ADDR_OFF_LSB = 2;
  localparam int unsigned ADDR_BLK_LSB = 8;
  localparam int unsigned ADDR_HI_LSB  = 10;

  localparam blk_idx_t BLK_IRQ   = 2'd0;
  localparam blk_idx_t BLK_GPIO  = 2'd1;
  localparam blk_idx_t BLK_TIMER = 2'd2;

  localparam reg_off_t IRQ_PENDING = 6'd0;
  localparam reg_off_t IRQ_ENABLE  = 6'd1;
  localparam reg_off_t IRQ_CLAIM   = 6'd2;
  localparam reg_off_t IRQ_MSIP    = 6'd3;

  localparam reg_off_t GPIO_DATA_IN    = 6'd0;
  localparam reg_off_t GPIO_DATA_OUT   = 6'd1;
  localparam reg_off_t GPIO_OUT_EN     = 6'd2;
  localparam reg_off_t GPIO_INTR_EN    = 6'd3;
  localparam reg_off_t GPIO_INTR_STATE = 6'd4;

  localparam reg_off_t TIMER_MTIME    = 6'd0;
  localparam reg_off_t TIMER_MTIMECMP = 6'd1;
  localparam reg_off_t TIMER_CTRL     = 6'd2;

  // CTRL fields
  localparam int unsigned TIMER_CTRL_EN_BIT  = 0;
  localparam int unsigned TIMER_CTRL_PRE_LSB = 8;

endpackage
